// ==== bpu.f ====
bpu_pkg.sv
bpu_pc_stage.sv
bpu_btb.sv
bpu_dir_pred.sv
bpu_ras.sv
bpu_next_pc.sv
bpu_top.sv
bpu_top_sva.sv
tb_bpu.sv

// ==== bpu_btb.sv ====
`timescale 1ns/1ns

// two-bank tagged btb, bank = pc[2] of the slot
module bpu_btb (
    input  logic                      clk,
    input  logic                      rst_n,
    input  bpu_pkg::addr_t            pc_i,           // fetch group pc
    input  logic                      wr_en_i,        // already qualified in the top
    input  bpu_pkg::addr_t            wr_pc_i,
    input  bpu_pkg::addr_t            wr_target_i,
    input  bpu_pkg::br_type_e         wr_type_i,
    input  logic                      wr_is_branch_i,
    output logic [1:0]                hit_o,
    output bpu_pkg::br_type_e [1:0]   type_o,
    output bpu_pkg::addr_t [1:0]      target_o,
    output logic [1:0]                is_branch_o
);
    import bpu_pkg::*;

    // entry fields kept as parallel arrays
    btb_tag_t tag_q    [2][BPU_BTB_DEPTH];
    addr_t    target_q [2][BPU_BTB_DEPTH];
    br_type_e type_q   [2][BPU_BTB_DEPTH];
    logic     isbr_q   [2][BPU_BTB_DEPTH];

    btb_idx_t rd_idx;
    btb_tag_t rd_tag;
    btb_idx_t wr_idx;
    logic     wr_bank;

    assign rd_idx  = btb_hash(pc_i);
    assign rd_tag  = btb_tag_of(pc_i);
    assign wr_idx  = btb_hash(wr_pc_i);
    assign wr_bank = wr_pc_i[2];    // slot of the corrected branch

    // both banks read at the same index, async read
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            type_o[b]      = type_q[b][rd_idx];
            target_o[b]    = target_q[b][rd_idx];
            is_branch_o[b] = isbr_q[b][rd_idx];
            hit_o[b]       = isbr_q[b][rd_idx] && (tag_q[b][rd_idx] == rd_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // empty btb, nothing hits
            for (int b = 0; b < 2; b++) begin
                for (int e = 0; e < BPU_BTB_DEPTH; e++) begin
                    tag_q[b][e]    <= '0;
                    target_q[b][e] <= '0;
                    type_q[b][e]   <= BR_NORMAL;
                    isbr_q[b][e]   <= 1'b0;
                end
            end
        end else if (wr_en_i) begin
            // install or overwrite on a miss
            tag_q[wr_bank][wr_idx]    <= btb_tag_of(wr_pc_i);
            target_q[wr_bank][wr_idx] <= wr_target_i;
            type_q[wr_bank][wr_idx]   <= wr_type_i;
            isbr_q[wr_bank][wr_idx]   <= wr_is_branch_i;
        end
    end

endmodule

// ==== bpu_dir_pred.sv ====
`timescale 1ns/1ns

// local history predictor: bht of histories feeding a pht of 2-bit counters
module bpu_dir_pred (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bpu_pkg::addr_t          pc_i,             // fetch group pc
    input  logic                    upd_i,            // applied correction
    input  bpu_pkg::addr_t          upd_pc_i,
    input  logic                    upd_taken_i,
    input  logic                    upd_type_miss_i,
    input  bpu_pkg::scnt_t          upd_scnt_i,       // counter seen at predict time
    input  bpu_pkg::hist_t          upd_hist_i,       // history seen at predict time
    output bpu_pkg::hist_t [1:0]    hist_o,
    output bpu_pkg::scnt_t [1:0]    scnt_o
);
    import bpu_pkg::*;

    hist_t bht_q [2][BPU_BTB_DEPTH];
    scnt_t pht_q [2][BPU_PHT_DEPTH];

    btb_idx_t bht_rd_idx;
    btb_idx_t bht_wr_idx;
    hist_t    bht_wdata;
    pht_idx_t pht_rd_idx [2];
    pht_idx_t pht_wr_idx;
    scnt_t    pht_wdata;
    logic     upd_bank;

    assign bht_rd_idx = btb_hash(pc_i);     // same index as the btb
    assign bht_wr_idx = btb_hash(upd_pc_i);
    assign upd_bank   = upd_pc_i[2];

    // lookup chain, history then counter, same cycle
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            hist_o[b]     = bht_q[b][bht_rd_idx];
            pht_rd_idx[b] = pht_index(hist_o[b], pc_i);
            scnt_o[b]     = pht_q[b][pht_rd_idx[b]];
        end
    end

    // new branch in this entry restarts its history
    always_comb begin
        if (upd_type_miss_i) begin
            bht_wdata = {{(BPU_HIST_LEN-1){1'b0}}, upd_taken_i};
        end else begin
            bht_wdata = {upd_hist_i[BPU_HIST_LEN-2:0], upd_taken_i};  // shift in outcome
        end
    end

    assign pht_wr_idx = pht_index(upd_hist_i, upd_pc_i);
    assign pht_wdata  = scnt_next(upd_scnt_i, upd_taken_i);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < 2; b++) begin
                for (int e = 0; e < BPU_BTB_DEPTH; e++) begin
                    bht_q[b][e] <= '0;
                end
            end
        end else if (upd_i) begin
            bht_q[upd_bank][bht_wr_idx] <= bht_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < 2; b++) begin
                for (int e = 0; e < BPU_PHT_DEPTH; e++) begin
                    pht_q[b][e] <= 2'b00;   // strong not taken
                end
            end
        end else if (upd_i) begin
            pht_q[upd_bank][pht_wr_idx] <= pht_wdata;
        end
    end

endmodule

// ==== bpu_next_pc.sv ====
`timescale 1ns/1ns

// per-slot decision and the next fetch address
module bpu_next_pc (
    input  bpu_pkg::addr_t            pc_i,
    input  logic [1:0]                hit_i,
    input  bpu_pkg::br_type_e [1:0]   type_i,
    input  bpu_pkg::addr_t [1:0]      target_i,     // btb targets
    input  bpu_pkg::scnt_t [1:0]      scnt_i,
    input  bpu_pkg::addr_t            ras_top_i,
    output logic [1:0]                taken_o,
    output bpu_pkg::addr_t [1:0]      target_o,
    output bpu_pkg::addr_t [1:0]      slot_next_o,
    output logic [1:0]                mask_o,
    output bpu_pkg::addr_t            pc_next_o
);
    import bpu_pkg::*;

    addr_t grp_base;      // 8-byte aligned group
    addr_t grp_plus4;
    addr_t grp_plus8;

    assign grp_base  = {pc_i[31:3], 3'b000};
    assign grp_plus4 = grp_base + 32'd4;
    assign grp_plus8 = grp_base + 32'd8;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            // unconditional types always go, conditional follow counter msb
            taken_o[s]  = hit_i[s] && ((type_i[s] != BR_NORMAL) || scnt_i[s][1]);
            target_o[s] = (type_i[s] == BR_RET) ? ras_top_i : target_i[s];
        end
    end

    assign slot_next_o[0] = taken_o[0] ? target_o[0] : grp_plus4;
    assign slot_next_o[1] = taken_o[1] ? target_o[1] : grp_plus8;

    // slot 0 valid only when entering at the low word
    // slot 1 dropped when slot 0 leaves the group
    assign mask_o[0] = !pc_i[2];
    assign mask_o[1] = !taken_o[0] || pc_i[2];

    always_comb begin
        pc_next_o = grp_plus8;  // fall through to next group
        if (taken_o[0] && !pc_i[2]) begin
            pc_next_o = target_o[0];
        end else if (taken_o[1]) begin
            pc_next_o = target_o[1];
        end
    end

endmodule

// ==== bpu_pc_stage.sv ====
`timescale 1ns/1ns

// fetch pc register, one fetch group in flight
module bpu_pc_stage #(
    parameter bpu_pkg::addr_t INIT_PC = bpu_pkg::BPU_INIT_PC
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           flush_i,     // backend redirect
    input  bpu_pkg::addr_t redir_pc_i,
    input  logic           ready_i,     // fetch unit accepts the group
    input  bpu_pkg::addr_t pc_next_i,   // from the next-pc stage
    output bpu_pkg::addr_t pc_o
);
    import bpu_pkg::*;

    addr_t pc_q;
    addr_t pc_d;

    // flush beats ready, otherwise hold
    always_comb begin
        pc_d = pc_q;
        if (flush_i) begin
            pc_d = redir_pc_i;
        end else if (ready_i) begin
            pc_d = pc_next_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= INIT_PC;  // boot address
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;   // drives all lookups this cycle

endmodule

// ==== bpu_pkg.sv ====
package bpu_pkg;

    // table geometry
    localparam int BPU_HIST_LEN   = 5;      // local history bits per branch
    localparam int BPU_BTB_LEN    = 9;      // btb / bht index bits
    localparam int BPU_TAG_LEN    = 8;      // btb tag bits, pc[19:12]
    localparam int BPU_PHT_PC_LEN = 8;      // pc[10:3] part of the pht index
    localparam int BPU_PHT_LEN    = BPU_HIST_LEN + BPU_PHT_PC_LEN;
    localparam int BPU_BTB_DEPTH  = 1 << BPU_BTB_LEN;   // entries per bank
    localparam int BPU_PHT_DEPTH  = 1 << BPU_PHT_LEN;   // counters per bank

    // defaults, overridden from the top
    localparam int BPU_RAS_DEPTH = 8;
    localparam logic [31:0] BPU_INIT_PC = 32'h1c00_0000;

    typedef logic [31:0]              addr_t;
    typedef logic [1:0]               scnt_t;     // 00 snt, 01 wnt, 10 wt, 11 st
    typedef logic [BPU_HIST_LEN-1:0]  hist_t;
    typedef logic [BPU_BTB_LEN-1:0]   btb_idx_t;
    typedef logic [BPU_TAG_LEN-1:0]   btb_tag_t;
    typedef logic [BPU_PHT_LEN-1:0]   pht_idx_t;

    typedef enum logic [1:0] {
        BR_NORMAL = 2'b00,  // conditional branch
        BR_JUMP   = 2'b01,  // B
        BR_CALL   = 2'b10,  // BL
        BR_RET    = 2'b11   // JIRL used as return
    } br_type_e;

    // folds two overlapping pc windows, tied to BPU_BTB_LEN = 9
    function automatic btb_idx_t btb_hash(input addr_t pc);
        return pc[17:9] ^ pc[11:3];
    endfunction

    function automatic btb_tag_t btb_tag_of(input addr_t pc);
        return pc[BPU_TAG_LEN+12-1:12];
    endfunction

    // history in the upper bits, group address below
    function automatic pht_idx_t pht_index(input hist_t hist, input addr_t pc);
        return {hist, pc[BPU_PHT_PC_LEN+3-1:3]};
    endfunction

    function automatic scnt_t scnt_next(input scnt_t cnt, input logic taken);
        scnt_t res;
        if (taken) begin
            res = (cnt == 2'b11) ? 2'b11 : cnt + 2'b01;   // saturate at strong taken
        end else begin
            res = (cnt == 2'b00) ? 2'b00 : cnt - 2'b01;   // saturate at strong not taken
        end
        return res;
    endfunction

endpackage

// ==== bpu_ras.sv ====
`timescale 1ns/1ns

// circular return address stack, overflow overwrites the oldest entry
module bpu_ras #(
    parameter int RAS_DEPTH = bpu_pkg::BPU_RAS_DEPTH   // power of two
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push_i,        // call retired
    input  logic           pop_i,         // return retired
    input  bpu_pkg::addr_t push_addr_i,   // call pc + 4
    output bpu_pkg::addr_t top_o
);
    import bpu_pkg::*;

    localparam int PTR_W = $clog2(RAS_DEPTH);

    typedef logic [PTR_W-1:0] ras_ptr_t;

    addr_t    stack_q [RAS_DEPTH];
    ras_ptr_t top_ptr;    // newest valid entry
    ras_ptr_t wr_ptr;     // next free slot

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RAS_DEPTH; i++) begin
                stack_q[i] <= '0;
            end
            top_ptr <= '1;  // one below wr_ptr
            wr_ptr  <= '0;
        end else if (push_i) begin
            stack_q[wr_ptr] <= push_addr_i;
            top_ptr         <= wr_ptr;
            wr_ptr          <= wr_ptr + 1'b1;   // wraps naturally
        end else if (pop_i) begin
            wr_ptr  <= top_ptr;
            top_ptr <= top_ptr - 1'b1;
        end
    end

    assign top_o = stack_q[top_ptr];

endmodule

// ==== bpu_top.sv ====
`timescale 1ns/1ns

// two-wide branch prediction unit, single-cycle lookup
module bpu_top #(
    parameter bpu_pkg::addr_t INIT_PC   = bpu_pkg::BPU_INIT_PC,
    parameter int             RAS_DEPTH = bpu_pkg::BPU_RAS_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush_i,
    input  bpu_pkg::addr_t            redir_pc_i,
    input  logic                      fetch_ready_i,
    // backend corrections, two slots
    input  logic [1:0]                cor_update_i,
    input  bpu_pkg::addr_t [1:0]      cor_pc_i,
    input  bpu_pkg::addr_t [1:0]      cor_target_i,
    input  bpu_pkg::br_type_e [1:0]   cor_type_i,
    input  logic [1:0]                cor_is_branch_i,
    input  logic [1:0]                cor_taken_i,
    input  logic [1:0]                cor_type_miss_i,
    input  logic [1:0]                cor_target_miss_i,
    input  bpu_pkg::scnt_t [1:0]      cor_scnt_i,
    input  bpu_pkg::hist_t [1:0]      cor_hist_i,
    // prediction to fetch
    output logic                      pred_valid_o,
    output bpu_pkg::addr_t            pc_o,
    output logic [1:0]                mask_o,
    output logic [1:0]                taken_o,
    output bpu_pkg::addr_t [1:0]      target_o,
    output bpu_pkg::addr_t [1:0]      next_pc_o,
    output bpu_pkg::br_type_e [1:0]   br_type_o,
    output logic [1:0]                is_branch_o,
    output bpu_pkg::scnt_t [1:0]      scnt_o,
    output bpu_pkg::hist_t [1:0]      hist_o,
    output logic [1:0]                need_update_o
);
    import bpu_pkg::*;

    logic valid_q;
    addr_t fetch_pc;
    addr_t pc_next;
    logic [1:0] btb_hit;
    br_type_e [1:0] btb_type;
    addr_t [1:0] btb_target;
    logic [1:0] btb_is_branch;
    hist_t [1:0] dir_hist;
    scnt_t [1:0] dir_scnt;
    addr_t ras_top;

    // applied correction
    logic c_sel;
    logic c_update;
    addr_t c_pc;
    addr_t c_target;
    br_type_e c_type;
    logic c_is_branch, c_taken, c_type_miss, c_target_miss;
    scnt_t c_scnt;
    hist_t c_hist;
    logic btb_we, ras_push, ras_pop;

    assign c_sel         = !cor_update_i[0];    // first slot marked for update wins
    assign c_update      = cor_update_i[c_sel];
    assign c_pc          = cor_pc_i[c_sel];
    assign c_target      = cor_target_i[c_sel];
    assign c_type        = cor_type_i[c_sel];
    assign c_is_branch   = cor_is_branch_i[c_sel];
    assign c_taken       = cor_taken_i[c_sel];
    assign c_type_miss   = cor_type_miss_i[c_sel];
    assign c_target_miss = cor_target_miss_i[c_sel];
    assign c_scnt        = cor_scnt_i[c_sel];
    assign c_hist        = cor_hist_i[c_sel];

    assign btb_we   = c_update && (c_type_miss || c_target_miss);
    assign ras_push = c_update && (c_type == BR_CALL);
    assign ras_pop  = c_update && (c_type == BR_RET);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;  // a prediction resolves every cycle
        end
    end

    bpu_pc_stage #(.INIT_PC(INIT_PC)) u_pc_stage (
        .clk(clk), .rst_n(rst_n), .flush_i(flush_i), .redir_pc_i(redir_pc_i),
        .ready_i(fetch_ready_i), .pc_next_i(pc_next), .pc_o(fetch_pc)
    );

    bpu_btb u_btb (
        .clk(clk), .rst_n(rst_n), .pc_i(fetch_pc), .wr_en_i(btb_we), .wr_pc_i(c_pc),
        .wr_target_i(c_target), .wr_type_i(c_type), .wr_is_branch_i(c_is_branch),
        .hit_o(btb_hit), .type_o(btb_type), .target_o(btb_target),
        .is_branch_o(btb_is_branch)
    );

    bpu_dir_pred u_dir_pred (
        .clk(clk), .rst_n(rst_n), .pc_i(fetch_pc), .upd_i(c_update), .upd_pc_i(c_pc),
        .upd_taken_i(c_taken), .upd_type_miss_i(c_type_miss), .upd_scnt_i(c_scnt),
        .upd_hist_i(c_hist), .hist_o(dir_hist), .scnt_o(dir_scnt)
    );

    bpu_ras #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
        .clk(clk), .rst_n(rst_n), .push_i(ras_push), .pop_i(ras_pop),
        .push_addr_i(c_pc + 32'd4), .top_o(ras_top)   // return lands after the call
    );

    bpu_next_pc u_next_pc (
        .pc_i(fetch_pc), .hit_i(btb_hit), .type_i(btb_type), .target_i(btb_target),
        .scnt_i(dir_scnt), .ras_top_i(ras_top), .taken_o(taken_o), .target_o(target_o),
        .slot_next_o(next_pc_o), .mask_o(mask_o), .pc_next_o(pc_next)
    );

    assign pred_valid_o  = valid_q;
    assign pc_o          = fetch_pc;
    assign br_type_o     = btb_type;
    assign is_branch_o   = btb_is_branch;
    assign scnt_o        = dir_scnt;
    assign hist_o        = dir_hist;
    assign need_update_o = ~btb_hit;    // backend installs on a miss

endmodule

// ==== bpu_top_sva.sv ====
`timescale 1ns/1ns

// prediction and fetch-pc checks, bound into bpu_top
module bpu_top_sva #(
    parameter bpu_pkg::addr_t INIT_PC = bpu_pkg::BPU_INIT_PC
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    flush_i,
    input bpu_pkg::addr_t          redir_pc_i,
    input logic                    fetch_ready_i,
    input logic [1:0]              cor_update_i,
    input bpu_pkg::addr_t [1:0]    cor_pc_i,
    input bpu_pkg::br_type_e [1:0] cor_type_i,
    input logic                    pred_valid_o,
    input bpu_pkg::addr_t          pc_o,
    input logic [1:0]              mask_o,
    input logic [1:0]              taken_o,
    input bpu_pkg::addr_t [1:0]    target_o,
    input bpu_pkg::br_type_e [1:0] br_type_o,
    input bpu_pkg::scnt_t [1:0]    scnt_o,
    input logic [1:0]              need_update_o
);
    import bpu_pkg::*;

    int unsigned fail_cnt = 0;  // failed assertions so far
    logic  csel;                // applied correction slot
    addr_t ret_exp;             // last pushed return address
    logic  ret_vld;

    assign csel = !cor_update_i[0];     // first marked slot is applied

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret_vld <= 1'b0;
        end else if (cor_update_i[csel] && (cor_type_i[csel] == BR_CALL)) begin
            ret_exp <= cor_pc_i[csel] + 32'd4;  // return lands after the call
            ret_vld <= 1'b1;
        end else if (cor_update_i[csel] && (cor_type_i[csel] == BR_RET)) begin
            ret_vld <= 1'b0;    // popped, older entries not tracked
        end
    end

    a_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (pc_o == INIT_PC) && (taken_o == 2'b00))
        else begin
            $error("fetch pc or taken wrong right after reset");
            fail_cnt++;
        end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n) $past(rst_n) |-> pred_valid_o)
        else begin
            $error("prediction not valid out of reset");
            fail_cnt++;
        end

    // no taken slot, fall through to the next aligned group
    a_seq: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ready_i && !flush_i && (taken_o == 2'b00)
        |=> pc_o == $past({pc_o[31:3], 3'b000}) + 32'd8)
        else begin
            $error("sequential fetch pc wrong");
            fail_cnt++;
        end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        !flush_i && !fetch_ready_i |=> $stable(pc_o))
        else begin
            $error("fetch pc moved during a stall");
            fail_cnt++;
        end

    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> pc_o == $past(redir_pc_i))
        else begin
            $error("fetch pc does not follow the redirect");
            fail_cnt++;
        end

    a_mask: assert property (@(posedge clk) disable iff (!rst_n)
        mask_o == {!taken_o[0] || pc_o[2], !pc_o[2]})
        else begin
            $error("slot mask wrong");
            fail_cnt++;
        end

    for (genvar s = 0; s < 2; s++) begin : g_slot
        // conditional hit follows the counter msb
        a_cond: assert property (@(posedge clk) disable iff (!rst_n)
            !need_update_o[s] && (br_type_o[s] == BR_NORMAL) |-> taken_o[s] == scnt_o[s][1])
            else begin
                $error("conditional slot %0d taken does not match its counter", s);
                fail_cnt++;
            end

        a_ret: assert property (@(posedge clk) disable iff (!rst_n)
            ret_vld && !need_update_o[s] && (br_type_o[s] == BR_RET) |-> target_o[s] == ret_exp)
            else begin
                $error("return slot %0d target is not the pushed address", s);
                fail_cnt++;
            end
    end

endmodule

bind bpu_top bpu_top_sva #(.INIT_PC(INIT_PC)) u_sva (.*);

// ==== tb_bpu.sv ====
`timescale 1ns/1ns

// testbench for bpu_top, most checking sits in bpu_top_sva
module tb_bpu;
    import bpu_pkg::*;

    localparam addr_t INIT_PC      = BPU_INIT_PC;
    localparam int    RESET_CYCLES = 10;
    localparam int    DIR_CYCLES   = 140;    // directed part, with margin
    localparam int    RAND_CYCLES  = 600;
    localparam int    LIMIT_CYCLES = 4 * (RESET_CYCLES + DIR_CYCLES + RAND_CYCLES);

    logic clk, rst_n, flush, fetch_ready, pred_valid;
    addr_t redir_pc, pc;
    logic [1:0] cor_update, cor_is_branch, cor_taken, cor_type_miss, cor_target_miss;
    addr_t [1:0] cor_pc, cor_target, target, next_pc;
    br_type_e [1:0] cor_type, br_type;
    scnt_t [1:0] cor_scnt, scnt;
    hist_t [1:0] cor_hist, hist;
    logic [1:0] mask, taken, is_branch, need_update;
    logic [31:0] lcg_state;

    bpu_top #(.INIT_PC(INIT_PC), .RAS_DEPTH(8)) DUT (
        .clk(clk), .rst_n(rst_n), .flush_i(flush), .redir_pc_i(redir_pc),
        .fetch_ready_i(fetch_ready), .cor_update_i(cor_update), .cor_pc_i(cor_pc),
        .cor_target_i(cor_target), .cor_type_i(cor_type), .cor_is_branch_i(cor_is_branch),
        .cor_taken_i(cor_taken), .cor_type_miss_i(cor_type_miss),
        .cor_target_miss_i(cor_target_miss), .cor_scnt_i(cor_scnt), .cor_hist_i(cor_hist),
        .pred_valid_o(pred_valid), .pc_o(pc), .mask_o(mask), .taken_o(taken),
        .target_o(target), .next_pc_o(next_pc), .br_type_o(br_type),
        .is_branch_o(is_branch), .scnt_o(scnt), .hist_o(hist), .need_update_o(need_update)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    // stop at the first failed assertion
    always @(negedge clk) begin
        if (DUT.u_sva.fail_cnt != 0) begin
            fail_now("assertion in bpu_top_sva failed");
        end
    end

    task automatic fail_now(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected counter after a taken outcome, stops at strong taken
    function automatic scnt_t count_up(input scnt_t cnt);
        return (cnt == 2'b11) ? cnt : cnt + 2'b01;
    endfunction

    // one correction slot, goes out with the next commit
    task automatic set_correction(input logic s, input addr_t a, input addr_t tgt,
                                  input br_type_e ty, input logic tk, input logic tmiss,
                                  input logic gmiss, input scnt_t sc, input hist_t h);
        cor_update[s]      = 1'b1;
        cor_pc[s]          = a;
        cor_target[s]      = tgt;
        cor_type[s]        = ty;
        cor_is_branch[s]   = 1'b1;
        cor_taken[s]       = tk;
        cor_type_miss[s]   = tmiss;
        cor_target_miss[s] = gmiss;
        cor_scnt[s]        = sc;
        cor_hist[s]        = h;
    endtask

    task automatic commit_corrections();
        @(negedge clk);     // table write at the edge in between
        cor_update = 2'b00;
    endtask

    task automatic flush_to(input addr_t a);
        flush    = 1'b1;
        redir_pc = a;
        @(negedge clk);
        flush = 1'b0;
        check_eq("pc after flush", pc, a);
    endtask

    initial begin
        addr_t held;
        scnt_t fed;
        scnt_t exp_cnt;
        logic [31:0] r;
        logic [31:0] q;

        lcg_state   = 32'he551_b4df;
        rst_n       = 1'b0;
        fetch_ready = 1'b1;
        flush       = 1'b0;
        redir_pc    = '0;
        set_correction(1'b0, '0, '0, BR_NORMAL, 1'b0, 1'b0, 1'b0, 2'b00, '0);
        set_correction(1'b1, '0, '0, BR_NORMAL, 1'b0, 1'b0, 1'b0, 2'b00, '0);
        cor_update  = 2'b00;
        repeat (RESET_CYCLES) @(negedge clk);
        check_eq("valid in reset", pred_valid, 1'b0);
        check_eq("pc in reset", pc, INIT_PC);
        rst_n = 1'b1;

        // sequential fetch out of reset
        @(negedge clk);
        check_eq("valid", pred_valid, 1'b1);
        check_eq("pc", pc, INIT_PC + 32'd8);
        check_eq("slot 1 next pc", next_pc[1], INIT_PC + 32'd16);   // not taken, group + 8
        repeat (3) @(negedge clk);
        check_eq("pc", pc, INIT_PC + 32'd32);

        // stall holds, flush wins over ready either way
        fetch_ready = 1'b0;
        held = pc;
        repeat (3) @(negedge clk);
        check_eq("pc in stall", pc, held);
        flush_to(32'h1c00_0104);
        fetch_ready = 1'b1;
        flush_to(32'h1c00_0200);

        // unconditional install in slot 1, then fetch at it
        set_correction(1'b0, 32'h1c00_2044, 32'h1c00_3000, BR_JUMP, 1'b1, 1'b1, 1'b1, 2'b00, '0);
        commit_corrections();
        flush_to(32'h1c00_2044);
        check_eq("jump taken", taken[1], 1'b1);
        check_eq("jump target", target[1], 32'h1c00_3000);
        check_eq("jump entry", is_branch[1], 1'b1);
        check_eq("empty slot 0", is_branch[0], 1'b0);
        check_eq("slot 0 next pc", next_pc[0], 32'h1c00_2044);  // group + 4
        check_eq("slot 1 next pc", next_pc[1], 32'h1c00_3000);
        @(negedge clk);
        check_eq("pc after jump", pc, 32'h1c00_3000);

        // all-ones history shifts in taken and stays put
        fetch_ready = 1'b0;
        flush_to(32'h1c00_4010);
        fed = 2'b00;
        for (int i = 0; i < 3; i++) begin
            exp_cnt = count_up(fed);
            set_correction(1'b0, 32'h1c00_4010, 32'h1c00_4800, BR_NORMAL, 1'b1, 1'b0,
                           (i == 0), fed, 5'b11111);
            commit_corrections();
            check_eq("history", hist[0], 5'b11111);
            check_eq("counter", scnt[0], exp_cnt);
            fed = exp_cnt;
        end
        fetch_ready = 1'b1;

        // return entry first, its pop leaves the later call on top
        set_correction(1'b0, 32'h1c00_9100, '0, BR_RET, 1'b1, 1'b1, 1'b1, 2'b00, '0);
        commit_corrections();
        set_correction(1'b0, 32'h1c00_5008, 32'h1c00_9100, BR_CALL, 1'b1, 1'b1, 1'b1, 2'b00, '0);
        commit_corrections();
        flush_to(32'h1c00_9100);
        check_eq("return hit", need_update[0], 1'b0);
        check_eq("return type", br_type[0], BR_RET);

        // both slots marked, slot 0 only
        set_correction(1'b0, 32'h1c00_6000, 32'h1c00_6800, BR_JUMP, 1'b1, 1'b1, 1'b1, 2'b00, '0);
        set_correction(1'b1, 32'h1c00_7004, 32'h1c00_7800, BR_JUMP, 1'b1, 1'b1, 1'b1, 2'b00, '0);
        commit_corrections();
        flush_to(32'h1c00_6000);
        check_eq("slot 0 installed", need_update[0], 1'b0);
        flush_to(32'h1c00_7004);
        check_eq("slot 1 not installed", need_update[1], 1'b1);

        for (int i = 0; i < RAND_CYCLES; i++) begin
            r = lcg_next();
            q = lcg_next();
            cor_update  = 2'b00;
            fetch_ready = (r[31:30] != 2'b00);      // stall about one cycle in four
            flush       = (r[29:27] == 3'b000);
            redir_pc    = INIT_PC + {r[7:2], 2'b00};    // small window, entries get hit
            if (q[31:29] == 3'b000) begin
                set_correction(q[28], INIT_PC + {q[7:2], 2'b00}, INIT_PC + {q[15:10], 2'b00},
                               q[27] ? BR_JUMP : BR_NORMAL, q[26], q[25], q[24], q[23:22],
                               q[21:17]);
            end
            @(negedge clk);
        end
        cor_update  = 2'b00;
        flush       = 1'b0;
        fetch_ready = 1'b1;
        repeat (2) @(negedge clk);

        if (DUT.u_sva.fail_cnt != 0) begin
            fail_now("assertion in bpu_top_sva failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule
